//--- hw/mem_port_arbiter.sv
`timescale 1ns/1ps

module mem_port_arbiter
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                rd_req,
    input  vtp_pkg::t_line_addr rd_adr,
    output logic                rd_ack,
    output vtp_pkg::t_line_data rd_dat,
    input  logic                pt_req,
    input  vtp_pkg::t_line_addr pt_adr,
    output logic                pt_ack,
    output vtp_pkg::t_line_data pt_dat,
    output logic                mem_cyc,
    output logic                mem_stb,
    output vtp_pkg::t_line_addr mem_adr,
    input  logic                mem_ack,
    input  vtp_pkg::t_line_data mem_dat
);

    // Transfer in progress and which requester owns it
    logic busy_q;
    logic owner_pt_q;
    logic owner_pt;

    // An idle bus is granted at once with the walker winning a tie.
    // while busy the registered owner keeps the port
    assign owner_pt = busy_q ? owner_pt_q : pt_req;

    assign mem_cyc = busy_q || pt_req || rd_req;
    assign mem_stb = mem_cyc;
    assign mem_adr = owner_pt ? pt_adr : rd_adr;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy_q <= 1'b0;
            owner_pt_q <= 1'b0;
        end
        else if (mem_ack)
        begin
            busy_q <= 1'b0;
        end
        else if (mem_cyc && !busy_q)
        begin
            // Lock the grant until the slave answers
            busy_q <= 1'b1;
            owner_pt_q <= pt_req;
        end
    end

    // Only the owner sees the acknowledge, data is shared
    assign pt_ack = mem_ack && owner_pt;
    assign rd_ack = mem_ack && !owner_pt;
    assign pt_dat = mem_dat;
    assign rd_dat = mem_dat;

    assert property (@(posedge clk) disable iff (!reset_n) mem_ack |-> mem_cyc);

endmodule

//--- hw/pt_walker.sv
`timescale 1ns/1ps

module pt_walker
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                walk_req,
    input  vtp_pkg::t_va_page   walk_page,
    output logic                walk_done,
    output logic                walk_fail,
    input  vtp_pkg::t_line_addr pt_base,
    input  logic                pt_base_valid,
    output logic                pt_req,
    output vtp_pkg::t_line_addr pt_adr,
    input  logic                pt_ack,
    input  vtp_pkg::t_line_data pt_dat,
    output logic                insert_en,
    output vtp_pkg::t_va_page   insert_page,
    output vtp_pkg::t_pa_page   insert_pa_page
);
    import vtp_pkg::*;

    localparam int PTE_BITS = 8 * PTE_BYTES;
    localparam int NUM_BITS = $clog2(PTES_PER_LINE + 1);

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_READ,
        S_SEARCH,
        S_INSERT,
        S_DONE,
        S_FAIL
    } t_state;

    t_state state;

    // Table base and a flag that it has been written since reset
    t_line_addr base_q;
    logic       base_loaded;

    // Page being resolved and the line currently in flight
    t_va_page   page_q;
    t_pt_idx    line_idx;
    t_pt_idx    next_idx;
    // Line under search, shifted down one entry per cycle
    t_line_data line_q;
    logic [NUM_BITS-1:0] pte_num;
    t_pa_page   pa_q;

    t_pt_tag  want_tag;
    t_pt_tag  cur_tag;
    t_pa_page cur_pa;

    assign want_tag = page_q[VA_PAGE_BITS-1 -: PT_TAG_BITS];
    // The entry at the bottom of the shifted line
    assign cur_pa = line_q[PA_PAGE_BITS-1:0];
    assign cur_tag = line_q[PA_PAGE_BITS +: PT_TAG_BITS];

    always_ff @(posedge clk)
    begin
        if (pt_base_valid)
        begin
            base_q <= pt_base;
        end
    end

    // ========================================
    // Walk FSM
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= S_IDLE;
            base_loaded <= 1'b0;
        end
        else
        begin
            if (pt_base_valid)
            begin
                base_loaded <= 1'b1;
            end

            case (state)
                S_IDLE:
                begin
                    // The hash line sits at the start of the table
                    if (walk_req && base_loaded)
                    begin
                        page_q <= walk_page;
                        line_idx <= t_pt_idx'(walk_page[PT_HASH_BITS-1:0]);
                        state <= S_READ;
                    end
                end
                S_READ:
                begin
                    if (pt_ack)
                    begin
                        line_q <= pt_dat;
                        next_idx <= pt_dat[8*PT_NEXT_BYTE +: PT_IDX_BITS];
                        pte_num <= '0;
                        state <= S_SEARCH;
                    end
                end
                S_SEARCH:
                begin
                    if (pte_num == NUM_BITS'(PTES_PER_LINE))
                    begin
                        // Line exhausted, so follow the overflow chain
                        if (next_idx == '0)
                        begin
                            state <= S_FAIL;
                        end
                        else
                        begin
                            line_idx <= next_idx;
                            state <= S_READ;
                        end
                    end
                    else if (cur_tag == '0)
                    begin
                        // An empty entry ends the list
                        state <= S_FAIL;
                    end
                    else if (cur_tag == want_tag)
                    begin
                        pa_q <= cur_pa;
                        state <= S_INSERT;
                    end
                    else
                    begin
                        line_q <= line_q >> PTE_BITS;
                        pte_num <= NUM_BITS'(pte_num + 1'b1);
                    end
                end
                // Insert lands one cycle ahead of done so the retry hits
                S_INSERT:
                begin
                    state <= S_DONE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign pt_req = (state == S_READ);
    assign pt_adr = base_q + t_line_addr'(line_idx);
    assign insert_en = (state == S_INSERT);
    assign insert_page = page_q;
    assign insert_pa_page = pa_q;
    assign walk_done = (state == S_DONE);
    assign walk_fail = (state == S_FAIL);

    // The arbiter routes an acknowledge here only for a read this block owns
    assert property (@(posedge clk) disable iff (!reset_n) pt_ack |-> pt_req);

endmodule

//--- hw/tlb_assoc.sv
`timescale 1ns/1ps

module tlb_assoc
#(
    parameter int TLB_SETS = 16,
    parameter int TLB_WAYS = 4
)
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              lookup_en,
    input  vtp_pkg::t_va_page lookup_page,
    output logic              lookup_rdy,
    output logic              lookup_hit,
    output vtp_pkg::t_pa_page lookup_pa_page,
    input  logic              insert_en,
    input  vtp_pkg::t_va_page insert_page,
    input  vtp_pkg::t_pa_page insert_pa_page
);
    import vtp_pkg::*;

    localparam int SET_BITS = $clog2(TLB_SETS);
    localparam int WAY_BITS = (TLB_WAYS > 1) ? $clog2(TLB_WAYS) : 1;
    // The set index is taken off the bottom of the page, the rest is the tag
    localparam int TAG_BITS = VA_PAGE_BITS - SET_BITS;

    typedef logic [SET_BITS-1:0] t_set;
    typedef logic [TAG_BITS-1:0] t_tag;
    typedef logic [WAY_BITS-1:0] t_way;

    // Every way has its own storage so one way is written without touching the others
    logic     valid_q [TLB_WAYS][TLB_SETS];
    t_tag     tag_q [TLB_WAYS][TLB_SETS];
    t_pa_page pa_q [TLB_WAYS][TLB_SETS];
    // Round-robin victim pointer of each set
    t_way     victim_q [TLB_SETS];

    // The top bit of the sweep counter marks the end of initialization
    logic [SET_BITS:0] init_idx;
    logic              initialized;

    t_set ins_set;
    t_tag ins_tag;
    t_way ins_way;

    t_va_page            look_q;
    logic                did_lookup;
    t_set                look_set;
    t_tag                look_tag;
    logic [TLB_WAYS-1:0] way_hit;

    assign initialized = init_idx[SET_BITS];
    assign lookup_rdy = initialized;

    assign {ins_tag, ins_set} = insert_page;
    assign ins_way = victim_q[ins_set];
    assign {look_tag, look_set} = look_q;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            init_idx <= '0;
            did_lookup <= 1'b0;
        end
        else
        begin
            if (!initialized)
            begin
                init_idx <= init_idx + 1'b1;
            end
            // The compare happens in the cycle after the request
            did_lookup <= lookup_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_en)
        begin
            look_q <= lookup_page;
        end
    end

    // ========================================
    // Storage update
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!initialized)
        begin
            // Sweep clears one set per cycle, all ways at once
            for (int w = 0; w < TLB_WAYS; w++)
            begin
                valid_q[w][t_set'(init_idx)] <= 1'b0;
            end
            victim_q[t_set'(init_idx)] <= '0;
        end
        else if (insert_en)
        begin
            valid_q[ins_way][ins_set] <= 1'b1;
            tag_q[ins_way][ins_set] <= ins_tag;
            pa_q[ins_way][ins_set] <= insert_pa_page;
            // Next insert into this set evicts the following way
            if (ins_way == t_way'(TLB_WAYS - 1))
            begin
                victim_q[ins_set] <= '0;
            end
            else
            begin
                victim_q[ins_set] <= t_way'(ins_way + 1'b1);
            end
        end
    end

    // Compare every way of the registered set against the tag
    always_comb
    begin
        lookup_pa_page = '0;
        for (int w = 0; w < TLB_WAYS; w++)
        begin
            way_hit[w] = valid_q[w][look_set] && (tag_q[w][look_set] == look_tag);
            if (way_hit[w])
            begin
                lookup_pa_page = pa_q[w][look_set];
            end
        end
    end

    assign lookup_hit = did_lookup && (|way_hit);

    // The controller must wait for the sweep before it looks anything up
    assert property (@(posedge clk) disable iff (!reset_n) lookup_en |-> lookup_rdy);

    // Walks only start on a miss, so a page never lands in two ways
    assert property (@(posedge clk) disable iff (!reset_n) did_lookup |-> $onehot0(way_hit));

endmodule

//--- hw/vtp_pkg.sv
package vtp_pkg;

    // ========================================
    // Address geometry
    // ========================================

    // Client and memory addresses count 128-bit lines, not bytes
    localparam int LINE_ADDR_BITS = 16;
    localparam int PAGE_OFFSET_BITS = 4;
    localparam int VA_PAGE_BITS = LINE_ADDR_BITS - PAGE_OFFSET_BITS;
    localparam int PA_PAGE_BITS = LINE_ADDR_BITS - PAGE_OFFSET_BITS;
    localparam int LINE_DATA_BITS = 128;

    typedef logic [LINE_ADDR_BITS-1:0] t_line_addr;
    typedef logic [PAGE_OFFSET_BITS-1:0] t_page_offset;
    typedef logic [VA_PAGE_BITS-1:0] t_va_page;
    typedef logic [PA_PAGE_BITS-1:0] t_pa_page;
    typedef logic [LINE_DATA_BITS-1:0] t_line_data;

    // ========================================
    // Host page table layout
    // ========================================

    // The low bits of the virtual page select the hash line
    localparam int PT_HASH_BITS = 6;
    // The remaining high bits are stored in each entry as the tag
    localparam int PT_TAG_BITS = VA_PAGE_BITS - PT_HASH_BITS;
    // Line index inside the table, wide enough to reach the overflow lines
    localparam int PT_IDX_BITS = 8;

    typedef logic [PT_TAG_BITS-1:0] t_pt_tag;
    typedef logic [PT_IDX_BITS-1:0] t_pt_idx;

    // One entry is the tag above the physical page, padded to whole bytes
    localparam int PTE_BYTES = (PT_TAG_BITS + PA_PAGE_BITS + 7) / 8;
    // Entry k starts at byte 3k of the line
    localparam int PTES_PER_LINE = 5;
    // The last byte links to the next line of the chain, zero ends it
    localparam int PT_NEXT_BYTE = 15;

endpackage

//--- hw/vtp_request_ctrl.sv
`timescale 1ns/1ps

module vtp_request_ctrl
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                cli_cyc,
    input  logic                cli_stb,
    input  vtp_pkg::t_line_addr cli_adr,
    input  logic                cli_adr_is_virtual,
    output logic                cli_ack,
    output logic                cli_err,
    output vtp_pkg::t_line_data cli_dat,
    input  logic                lookup_rdy,
    output logic                lookup_en,
    output vtp_pkg::t_va_page   lookup_page,
    input  logic                lookup_hit,
    input  vtp_pkg::t_pa_page   lookup_pa_page,
    output logic                walk_req,
    output vtp_pkg::t_va_page   walk_page,
    input  logic                walk_done,
    input  logic                walk_fail,
    output logic                rd_req,
    output vtp_pkg::t_line_addr rd_adr,
    input  logic                rd_ack,
    input  vtp_pkg::t_line_data rd_dat
);
    import vtp_pkg::*;

    typedef enum logic [2:0]
    {
        S_IDLE,
        S_LOOKUP,
        S_CHECK,
        S_WALK,
        S_READ,
        S_ACK,
        S_ERR
    } t_state;

    t_state state;

    t_line_addr   adr_q;
    t_line_addr   rd_adr_q;
    t_line_data   dat_q;
    t_page_offset offset;

    // The offset inside the page is the same for both address spaces
    assign offset = adr_q[PAGE_OFFSET_BITS-1:0];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= S_IDLE;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    // Physical lines skip the TLB
                    if (cli_cyc && cli_stb)
                    begin
                        adr_q <= cli_adr;
                        rd_adr_q <= cli_adr;
                        state <= cli_adr_is_virtual ? S_LOOKUP : S_READ;
                    end
                end
                // Hold here while the TLB is still sweeping
                S_LOOKUP:
                begin
                    if (lookup_rdy)
                    begin
                        state <= S_CHECK;
                    end
                end
                S_CHECK:
                begin
                    if (lookup_hit)
                    begin
                        rd_adr_q <= {lookup_pa_page, offset};
                        state <= S_READ;
                    end
                    else
                    begin
                        state <= S_WALK;
                    end
                end
                S_WALK:
                begin
                    // The translation is in the TLB by now, so look it up again
                    if (walk_done)
                    begin
                        state <= S_LOOKUP;
                    end
                    else if (walk_fail)
                    begin
                        state <= S_ERR;
                    end
                end
                S_READ:
                begin
                    if (rd_ack)
                    begin
                        dat_q <= rd_dat;
                        state <= S_ACK;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign lookup_en = (state == S_LOOKUP) && lookup_rdy;
    assign lookup_page = adr_q[LINE_ADDR_BITS-1:PAGE_OFFSET_BITS];
    assign walk_req = (state == S_WALK);
    assign walk_page = adr_q[LINE_ADDR_BITS-1:PAGE_OFFSET_BITS];
    assign rd_req = (state == S_READ);
    assign rd_adr = rd_adr_q;
    assign cli_ack = (state == S_ACK);
    assign cli_err = (state == S_ERR);
    assign cli_dat = dat_q;

    // A response ends a request the client is still holding, and only one kind fires
    assert property (@(posedge clk) disable iff (!reset_n)
        (cli_ack || cli_err) |-> (cli_cyc && cli_stb && !(cli_ack && cli_err)));

endmodule

//--- hw/vtp_translator.sv
`timescale 1ns/1ps

module vtp_translator
#(
    parameter int TLB_SETS = 16,
    parameter int TLB_WAYS = 4
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                cli_cyc,
    input  logic                cli_stb,
    input  vtp_pkg::t_line_addr cli_adr,
    input  logic                cli_adr_is_virtual,
    output logic                cli_ack,
    output logic                cli_err,
    output vtp_pkg::t_line_data cli_dat,
    output logic                mem_cyc,
    output logic                mem_stb,
    output vtp_pkg::t_line_addr mem_adr,
    input  logic                mem_ack,
    input  vtp_pkg::t_line_data mem_dat,
    input  vtp_pkg::t_line_addr pt_base,
    input  logic                pt_base_valid
);
    import vtp_pkg::*;

    // ========================================
    // Controller to TLB and walker
    // ========================================

    logic     lookup_en;
    logic     lookup_rdy;
    logic     lookup_hit;
    t_va_page lookup_page;
    t_pa_page lookup_pa_page;
    logic     walk_req;
    logic     walk_done;
    logic     walk_fail;
    t_va_page walk_page;

    // Walker fills the TLB
    logic     insert_en;
    t_va_page insert_page;
    t_pa_page insert_pa_page;

    // ========================================
    // Requesters on the memory port
    // ========================================

    logic       rd_req;
    logic       rd_ack;
    t_line_addr rd_adr;
    t_line_data rd_dat;
    logic       pt_req;
    logic       pt_ack;
    t_line_addr pt_adr;
    t_line_data pt_dat;

    vtp_request_ctrl i_vtp_request_ctrl
    (
        .clk, .reset_n,
        .cli_cyc, .cli_stb, .cli_adr, .cli_adr_is_virtual,
        .cli_ack, .cli_err, .cli_dat,
        .lookup_rdy, .lookup_en, .lookup_page, .lookup_hit, .lookup_pa_page,
        .walk_req, .walk_page, .walk_done, .walk_fail,
        .rd_req, .rd_adr, .rd_ack, .rd_dat
    );

    tlb_assoc
    #(
        .TLB_SETS(TLB_SETS),
        .TLB_WAYS(TLB_WAYS)
    )
    i_tlb_assoc
    (
        .clk, .reset_n,
        .lookup_en, .lookup_page, .lookup_rdy, .lookup_hit, .lookup_pa_page,
        .insert_en, .insert_page, .insert_pa_page
    );

    pt_walker i_pt_walker
    (
        .clk, .reset_n,
        .walk_req, .walk_page, .walk_done, .walk_fail,
        .pt_base, .pt_base_valid,
        .pt_req, .pt_adr, .pt_ack, .pt_dat,
        .insert_en, .insert_page, .insert_pa_page
    );

    mem_port_arbiter i_mem_port_arbiter
    (
        .clk, .reset_n,
        .rd_req, .rd_adr, .rd_ack, .rd_dat,
        .pt_req, .pt_adr, .pt_ack, .pt_dat,
        .mem_cyc, .mem_stb, .mem_adr, .mem_ack, .mem_dat
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the simulation with Verilator, run it and look for the pass line in the log
LOG=sim.log
BUILD_LOG=build.log
rm -rf obj_dir "$LOG" "$BUILD_LOG"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_vtp_translator -o sim_vtp > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/sim_vtp > "$LOG" 2>&1 \
    || { echo "Build or simulation run did not complete"; cat "$BUILD_LOG"; exit 1; }
cat "$LOG"
grep -q "^test passed$" "$LOG" \
    && { echo "Simulation reported a pass"; exit 0; } \
    || { echo "Simulation did not report a pass"; exit 1; }

//--- test/host_memory_model.sv
`timescale 1ns/1ps

module host_memory_model
#(
    parameter vtp_pkg::t_line_addr PT_BASE = 16'hF000
)
(
    input  logic                clk,
    input  logic                reset_n,
    input  logic                cyc,
    input  logic                stb,
    input  vtp_pkg::t_line_addr adr,
    output logic                ack,
    output vtp_pkg::t_line_data dat
);
    import vtp_pkg::*;

    localparam int PT_LINES = 2 ** PT_IDX_BITS;
    localparam int PTE_BITS = 8 * PTE_BYTES;

    // Page-table lines live in a window of PT_LINES lines starting at PT_BASE
    t_line_data pt_mem [PT_LINES];
    logic       active;
    logic [1:0] wait_cnt;
    integer     seed = 3679;

    // One entry is the tag stacked above the physical page
    function automatic logic [PTE_BITS-1:0] pte_word(input t_va_page vpage, input t_pa_page ppage);
        logic [PTE_BITS-1:0] pte;
        pte = '0;
        pte[PA_PAGE_BITS-1:0] = ppage;
        pte[PA_PAGE_BITS +: PT_TAG_BITS] = vpage[VA_PAGE_BITS-1 -: PT_TAG_BITS];
        return pte;
    endfunction

    task automatic put_pte(input int idx, input int slot, input t_va_page vpage,
                           input t_pa_page ppage);
        pt_mem[idx][PTE_BITS*slot +: PTE_BITS] = pte_word(vpage, ppage);
    endtask

    // The last byte of a line points to the next line of its chain
    task automatic link_line(input int idx, input t_pt_idx next);
        pt_mem[idx][8*PT_NEXT_BYTE +: PT_IDX_BITS] = next;
    endtask

    // Lines outside the table return their own address repeated across the word
    function automatic t_line_data read_line(input t_line_addr a);
        t_line_addr off;
        off = a - PT_BASE;
        if (off < PT_LINES)
        begin
            return pt_mem[off[PT_IDX_BITS-1:0]];
        end
        return {(LINE_DATA_BITS / LINE_ADDR_BITS){a}};
    endfunction

    // ========================================
    // Page table contents
    // ========================================

    initial
    begin
        for (int i = 0; i < PT_LINES; i++)
        begin
            pt_mem[i] = '0;
        end
        // Hash line 1 holds a single entry, the empty slot after it ends the list
        put_pte(1, 0, 12'h041, 12'h321);
        // Hash line 2 is full and chains into overflow line 64
        put_pte(2, 0, 12'h082, 12'h602);
        put_pte(2, 1, 12'h0C2, 12'h603);
        put_pte(2, 2, 12'h102, 12'h604);
        put_pte(2, 3, 12'h142, 12'h605);
        put_pte(2, 4, 12'h182, 12'h606);
        link_line(2, 8'd64);
        put_pte(64, 0, 12'h202, 12'h608);
        put_pte(64, 1, 12'h1C2, 12'h5A7);
        // Six pages of TLB set 5 spread over four hash lines
        put_pte(5, 0, 12'h045, 12'h445);
        put_pte(5, 1, 12'h085, 12'h485);
        put_pte(8'h15, 0, 12'h055, 12'h455);
        put_pte(8'h15, 1, 12'h095, 12'h495);
        put_pte(8'h25, 0, 12'h065, 12'h465);
        put_pte(8'h35, 0, 12'h075, 12'h475);
    end

    // Each transfer waits a random 0 to 3 cycles before its one-cycle acknowledge
    always @(posedge clk)
    begin
        if (!reset_n)
        begin
            ack <= 1'b0;
            active <= 1'b0;
            wait_cnt <= '0;
        end
        else if (ack)
        begin
            ack <= 1'b0;
        end
        else if (cyc && stb && !active)
        begin
            active <= 1'b1;
            wait_cnt <= 2'($random(seed) & 3);
        end
        else if (active && wait_cnt != 2'd0)
        begin
            wait_cnt <= wait_cnt - 2'd1;
        end
        else if (active)
        begin
            active <= 1'b0;
            ack <= 1'b1;
            dat <= read_line(adr);
        end
    end

endmodule

//--- test/tb_vtp_translator.sv
`timescale 1ns/1ps

module tb_vtp_translator;
    import vtp_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS = 19;
    // Longest wait for one response, also the per-test share of the watchdog
    localparam int WAIT_LIMIT = 200;
    localparam t_line_addr PT_BASE = 16'hF000;

    logic       clk;
    logic       reset_n;
    logic       cli_cyc;
    logic       cli_stb;
    t_line_addr cli_adr;
    logic       cli_adr_is_virtual;
    logic       cli_ack;
    logic       cli_err;
    t_line_data cli_dat;
    logic       mem_cyc;
    logic       mem_stb;
    t_line_addr mem_adr;
    logic       mem_ack;
    t_line_data mem_dat;
    t_line_addr pt_base;
    logic       pt_base_valid;

    // Stimulus table, one column per array
    string      test_name [NUM_TESTS];
    t_line_addr test_adr [NUM_TESTS];
    logic       test_virt [NUM_TESTS];
    logic       test_err [NUM_TESTS];
    t_line_addr test_phys [NUM_TESTS];
    int         table_len;

    int error_count;
    int test_count;
    int fail_count;

    vtp_translator
    #(
        .TLB_SETS(16),
        .TLB_WAYS(4)
    )
    i_vtp_translator
    (
        .clk, .reset_n,
        .cli_cyc, .cli_stb, .cli_adr, .cli_adr_is_virtual,
        .cli_ack, .cli_err, .cli_dat,
        .mem_cyc, .mem_stb, .mem_adr, .mem_ack, .mem_dat,
        .pt_base, .pt_base_valid
    );

    host_memory_model #(.PT_BASE(PT_BASE)) i_host_memory_model
    (
        .clk, .reset_n,
        .cyc(mem_cyc), .stb(mem_stb), .adr(mem_adr), .ack(mem_ack), .dat(mem_dat)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial
    begin
        #(NUM_TESTS * WAIT_LIMIT * CLK_PERIOD);
        $display("Watchdog expired before all tests had finished");
        $display("test failed");
        $finish;
    end

    // ========================================
    // Compare tasks and helpers
    // ========================================

    task automatic check_data(input string sig, input t_line_data got, input t_line_data exp);
        if (got !== exp)
        begin
            $display("ERROR t=%0t %s got %h expected %h", $time, sig, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(input string sig, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR t=%0t %s got %b expected %b", $time, sig, got, exp);
            error_count++;
        end
    endtask

    // Every data line outside the page table repeats its own address
    function automatic t_line_data line_pattern(input t_line_addr a);
        return {(LINE_DATA_BITS / LINE_ADDR_BITS){a}};
    endfunction

    task automatic add_test(input string name, input t_line_addr adr, input logic virt,
                            input logic err, input t_line_addr phys);
        test_name[table_len] = name;
        test_adr[table_len] = adr;
        test_virt[table_len] = virt;
        test_err[table_len] = err;
        test_phys[table_len] = phys;
        table_len++;
    endtask

    task automatic fill_table();
        add_test("physical_read", 16'h1234, 1'b0, 1'b0, 16'h1234);
        add_test("virtual_miss_walk", 16'h0415, 1'b1, 1'b0, 16'h3215);
        add_test("virtual_hit_repeat", 16'h0415, 1'b1, 1'b0, 16'h3215);
        add_test("overflow_chain", 16'h1C23, 1'b1, 1'b0, 16'h5A73);
        add_test("unmapped_empty_line", 16'h0437, 1'b1, 1'b1, 16'h0000);
        add_test("unmapped_zero_tag", 16'h0819, 1'b1, 1'b1, 16'h0000);
        add_test("valid_after_error", 16'h041A, 1'b1, 1'b0, 16'h321A);
        // Six pages of one TLB set, then the same six again after eviction
        for (int pass = 0; pass < 2; pass++)
        begin
            for (int k = 0; k < 6; k++)
            begin
                add_test(pass == 0 ? "set_fill" : "set_refill",
                         {4'h0, 4'(4 + k), 4'h5, pass == 0 ? 4'h7 : 4'hC}, 1'b1, 1'b0,
                         {4'h4, 4'(4 + k), 4'h5, pass == 0 ? 4'h7 : 4'hC});
            end
        end
    endtask

    // Holds the request until ack or err and checks the outcome against the table
    task automatic run_request(input int idx);
        int         cycles;
        logic       got_ack;
        logic       got_err;
        t_line_data got_dat;
        cycles = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        got_dat = '0;
        @(posedge clk);
        cli_cyc <= 1'b1;
        cli_stb <= 1'b1;
        cli_adr <= test_adr[idx];
        cli_adr_is_virtual <= test_virt[idx];
        // Responses are sampled halfway through the cycle
        while (!got_ack && !got_err && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            got_ack = cli_ack;
            got_err = cli_err;
            got_dat = cli_dat;
            cycles++;
        end
        @(posedge clk);
        cli_cyc <= 1'b0;
        cli_stb <= 1'b0;
        if (!got_ack && !got_err)
        begin
            $display("Request %s got no response within %0d cycles", test_name[idx], WAIT_LIMIT);
            error_count++;
        end
        else
        begin
            check_flag("cli_err", got_err, test_err[idx]);
            check_flag("cli_ack", got_ack, !test_err[idx]);
            if (!test_err[idx])
            begin
                check_data("cli_dat", got_dat, line_pattern(test_phys[idx]));
            end
        end
        // The response is a single-cycle pulse
        @(negedge clk);
        check_flag("cli_ack", cli_ack, 1'b0);
        check_flag("cli_err", cli_err, 1'b0);
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial
    begin
        int errors_before;
        error_count = 0;
        test_count = 0;
        fail_count = 0;
        table_len = 0;
        reset_n = 1'b0;
        cli_cyc = 1'b0;
        cli_stb = 1'b0;
        cli_adr = '0;
        cli_adr_is_virtual = 1'b0;
        pt_base = '0;
        pt_base_valid = 1'b0;
        fill_table();

        // Both ports stay quiet while reset is held and right after it
        errors_before = error_count;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_flag("cli_ack", cli_ack, 1'b0);
        check_flag("cli_err", cli_err, 1'b0);
        check_flag("mem_cyc", mem_cyc, 1'b0);
        check_flag("mem_stb", mem_stb, 1'b0);
        repeat (RESET_CYCLES - 3) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        pt_base <= PT_BASE;
        pt_base_valid <= 1'b1;
        @(posedge clk);
        pt_base_valid <= 1'b0;
        @(negedge clk);
        check_flag("cli_ack", cli_ack, 1'b0);
        check_flag("cli_err", cli_err, 1'b0);
        check_flag("mem_cyc", mem_cyc, 1'b0);
        check_flag("mem_stb", mem_stb, 1'b0);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("PASS reset_idle");
        end
        else
        begin
            fail_count++;
            $display("FAIL reset_idle");
        end

        for (int i = 0; i < table_len; i++)
        begin
            errors_before = error_count;
            run_request(i);
            test_count++;
            if (error_count == errors_before)
            begin
                $display("PASS %0d %s", i, test_name[i]);
            end
            else
            begin
                fail_count++;
                $display("FAIL %0d %s", i, test_name[i]);
            end
        end

        $display("Tests run %0d, failed %0d, mismatches %0d", test_count, fail_count, error_count);
        if (error_count == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/vtp_pkg.sv
hw/tlb_assoc.sv
hw/pt_walker.sv
hw/mem_port_arbiter.sv
hw/vtp_request_ctrl.sv
hw/vtp_translator.sv
test/host_memory_model.sv
test/tb_vtp_translator.sv
